// ==== rtl/gpu_pkg.sv ====
/* shared widths, opcodes and FIFO thresholds for the 2D drawing engine
   plus the instruction word with its line and point views */
package gpu_pkg;

    // framebuffer geometry
    localparam int coord_w  = 5;     // 32 by 32 pixels
    localparam int color_w  = 8;     // rrr ggg bb
    localparam int fb_words = 1024;  // 32 * 32

    // pixel FIFO
    localparam int fifo_depth       = 8;
    localparam int fifo_pause_level = 6;  // two slots spare for pixels already in flight

    // opcodes, top two bits of every instruction
    localparam int op_w = 2;
    localparam logic [op_w-1:0] op_nop   = 2'd0;
    localparam logic [op_w-1:0] op_point = 2'd1;
    localparam logic [op_w-1:0] op_line  = 2'd2;

    localparam int inst_w = 30;

    // one 30 bit word, read either as a line or as a single point
    typedef union packed {
        struct packed {
            logic [op_w-1:0]    op;
            logic [coord_w-1:0] x1;     // start point
            logic [coord_w-1:0] y1;
            logic [coord_w-1:0] x2;     // end point
            logic [coord_w-1:0] y2;
            logic [color_w-1:0] color;
        } line;
        struct packed {
            logic [op_w-1:0]    op;
            logic [coord_w-1:0] x;
            logic [coord_w-1:0] y;
            logic [color_w-1:0] color;
            // low bits carry nothing in a point
            logic [inst_w-op_w-2*coord_w-color_w-1:0] pad;
        } point;
    } gpu_inst_t;

endpackage

// ==== rtl/gpu_inst_decoder.sv ====
/* instruction decoder, latches one instruction, starts the line walker
   or pushes a single point, and holds busy until the frame is written */
`timescale 1ns/1ns

module gpu_inst_decoder (
    input  logic                        clk,
    input  logic                        rst,
    input  gpu_pkg::gpu_inst_t          inst,
    input  logic                        inst_valid,
    input  logic                        finished,    // walker done with its line
    input  logic                        fifo_empty,
    output logic                        busy,
    output logic                        start,
    output logic [gpu_pkg::coord_w-1:0] x1,
    output logic [gpu_pkg::coord_w-1:0] y1,
    output logic [gpu_pkg::coord_w-1:0] x2,
    output logic [gpu_pkg::coord_w-1:0] y2,
    output logic [gpu_pkg::color_w-1:0] color,
    output logic                        point_push,
    output logic [gpu_pkg::coord_w-1:0] point_x,
    output logic [gpu_pkg::coord_w-1:0] point_y
);

    gpu_pkg::gpu_inst_t inst_q;   // held for the whole instruction
    logic               is_line;  // current job is a line
    logic               take;     // instruction accepted this cycle
    logic               new_line; // accepted one is a line
    logic               done;     // every pixel has reached the framebuffer

    // only taken while idle, nop is simply dropped
    assign take     = inst_valid && !busy && (inst.line.op != gpu_pkg::op_nop);
    assign new_line = (inst.line.op == gpu_pkg::op_line);  // reserved op 3 draws as a point

    // finished is stale while start is still high, so wait past it
    // point pixel is not yet in the FIFO during its push cycle
    assign done = busy && !start && !point_push && fifo_empty && (finished || !is_line);

    // instruction latch, payload only
    always_ff @(posedge clk) begin
        if (take) begin
            inst_q <= inst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            is_line    <= 1'b0;
            start      <= 1'b0;
            point_push <= 1'b0;
        end else begin
            start      <= take && new_line;   // one cycle pulse at t+1
            point_push <= take && !new_line;  // point pixel pushed at t+1
            if (take) begin
                busy    <= 1'b1;
                is_line <= new_line;
            end else if (done) begin
                busy    <= 1'b0;
            end
        end
    end

    // line view
    assign x1 = inst_q.line.x1;
    assign y1 = inst_q.line.y1;
    assign x2 = inst_q.line.x2;
    assign y2 = inst_q.line.y2;

    // point view
    assign point_x = inst_q.point.x;
    assign point_y = inst_q.point.y;

    // colour sits in different bits in each view
    assign color = is_line ? inst_q.line.color : inst_q.point.color;

endmodule

// ==== rtl/gpu_func_draw_line.sv ====
/* Bresenham line walker
   one pixel per unpaused cycle from (x1,y1) to (x2,y2), both ends included */
`timescale 1ns/1ns

module gpu_func_draw_line (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pause,     // FIFO nearly full
    input  logic                        start,
    output logic                        finished,
    input  logic [gpu_pkg::coord_w-1:0] x1,
    input  logic [gpu_pkg::coord_w-1:0] y1,
    input  logic [gpu_pkg::coord_w-1:0] x2,
    input  logic [gpu_pkg::coord_w-1:0] y2,
    input  logic [gpu_pkg::color_w-1:0] color_in,
    output logic [gpu_pkg::coord_w-1:0] pos_x,
    output logic [gpu_pkg::coord_w-1:0] pos_y,
    output logic [gpu_pkg::color_w-1:0] pixel_color,
    output logic                        pixel_valid
);

    // endpoint deltas, inputs are held stable by the decoder for the line
    logic [gpu_pkg::coord_w-1:0] dx_abs;
    logic [gpu_pkg::coord_w-1:0] dy_abs;
    logic                        x_dec;     // walk towards smaller x
    logic                        y_dec;     // walk towards smaller y
    logic                        steep;     // |dy| > |dx|, y is the major axis
    logic [gpu_pkg::coord_w-1:0] d_major;
    logic [gpu_pkg::coord_w-1:0] d_minor;

    // error term, range stays well inside +-4 * 32
    logic signed [gpu_pkg::coord_w+2:0] two_minor;
    logic signed [gpu_pkg::coord_w+2:0] two_major;
    logic signed [gpu_pkg::coord_w+2:0] err_init;
    logic signed [gpu_pkg::coord_w+2:0] err;

    logic                      active;   // walk in progress
    logic [gpu_pkg::coord_w:0] count;    // pixels still to emit, up to 32
    logic                      minor_step;
    logic                      step_x;
    logic                      step_y;

    assign x_dec  = (x2 < x1);
    assign y_dec  = (y2 < y1);
    assign dx_abs = x_dec ? x1 - x2 : x2 - x1;
    assign dy_abs = y_dec ? y1 - y2 : y2 - y1;

    // swap axes for steep lines
    assign steep   = (dy_abs > dx_abs);
    assign d_major = steep ? dy_abs : dx_abs;
    assign d_minor = steep ? dx_abs : dy_abs;

    assign two_minor = {2'b00, d_minor, 1'b0};
    assign two_major = {2'b00, d_major, 1'b0};
    assign err_init  = two_minor - $signed({3'b000, d_major});  // 2*dmin - dmaj

    // minor axis moves when the error is not negative
    assign minor_step = !err[gpu_pkg::coord_w+2];
    assign step_x     = steep ? minor_step : 1'b1;
    assign step_y     = steep ? 1'b1 : minor_step;

    // every visited pixel takes the line colour
    assign pixel_color = color_in;
    assign pixel_valid = active && !pause;   // never while paused or finished

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            finished <= 1'b0;
            count    <= '0;
        end else if (start) begin
            active   <= 1'b1;
            finished <= 1'b0;
            count    <= {1'b0, d_major} + {{gpu_pkg::coord_w{1'b0}}, 1'b1};  // dmaj + 1
        end else if (pixel_valid) begin
            count <= count - {{gpu_pkg::coord_w{1'b0}}, 1'b1};
            if (count == {{gpu_pkg::coord_w{1'b0}}, 1'b1}) begin  // last pixel out now
                active   <= 1'b0;
                finished <= 1'b1;
            end
        end
    end

    // position and error, held while paused
    always_ff @(posedge clk) begin
        if (start) begin
            pos_x <= x1;
            pos_y <= y1;
            err   <= err_init;
        end else if (pixel_valid) begin
            if (step_x) begin
                pos_x <= x_dec ? pos_x - 1'b1 : pos_x + 1'b1;
            end
            if (step_y) begin
                pos_y <= y_dec ? pos_y - 1'b1 : pos_y + 1'b1;
            end
            if (minor_step) begin
                err <= err + two_minor - two_major;
            end else begin
                err <= err + two_minor;
            end
        end
    end

endmodule

// ==== rtl/pixel_fifo.sv ====
/* eight entry pixel FIFO between the pixel producers and the frame writer
   raises pause at the almost full level to hold the line walker */
`timescale 1ns/1ns

module pixel_fifo (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  logic [gpu_pkg::coord_w-1:0] px,
    input  logic [gpu_pkg::coord_w-1:0] py,
    input  logic [gpu_pkg::color_w-1:0] pcolor,
    input  logic                        pop,
    output logic                        empty,
    output logic [gpu_pkg::coord_w-1:0] head_x,
    output logic [gpu_pkg::coord_w-1:0] head_y,
    output logic [gpu_pkg::color_w-1:0] head_color,
    output logic                        pause
);

    // entry is {x, y, colour}
    logic [2*gpu_pkg::coord_w+gpu_pkg::color_w-1:0] mem [gpu_pkg::fifo_depth];

    logic [$clog2(gpu_pkg::fifo_depth)-1:0] wr_ptr;
    logic [$clog2(gpu_pkg::fifo_depth)-1:0] rd_ptr;
    logic [$clog2(gpu_pkg::fifo_depth):0]   count;   // 0 to 8
    logic                                   do_push;
    logic                                   do_pop;

    assign do_push = push && (count != gpu_pkg::fifo_depth);  // full never reached in practice
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= {px, py, pcolor};
        end
    end

    // pointers wrap naturally at depth 8
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            pause  <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
            pause <= (count >= gpu_pkg::fifo_pause_level);  // one cycle late, hence the margin
        end
    end

    assign empty = (count == '0);
    assign {head_x, head_y, head_color} = mem[rd_ptr];  // shows up one cycle after push

endmodule

// ==== rtl/frame_writer.sv ====
/* frame writer, drains the pixel FIFO into the 32 by 32 framebuffer
   and serves the scan read port, which wins over writes */
`timescale 1ns/1ns

module frame_writer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        empty,
    input  logic [gpu_pkg::coord_w-1:0] head_x,
    input  logic [gpu_pkg::coord_w-1:0] head_y,
    input  logic [gpu_pkg::color_w-1:0] head_color,
    output logic                        pop,
    input  logic                        scan_req,    // level, blocks writes
    input  logic [gpu_pkg::coord_w-1:0] scan_x,
    input  logic [gpu_pkg::coord_w-1:0] scan_y,
    output logic [gpu_pkg::color_w-1:0] scan_color
);

    // framebuffer, contents undefined until painted
    logic [gpu_pkg::color_w-1:0] fb_mem [gpu_pkg::fb_words];

    logic [2*gpu_pkg::coord_w-1:0] wr_addr;
    logic [2*gpu_pkg::coord_w-1:0] rd_addr;

    // y * 32 + x
    assign wr_addr = {head_y, head_x};
    assign rd_addr = {scan_y, scan_x};

    // write and pop together, only when the scan port is idle
    assign pop = !empty && !scan_req;

    always_ff @(posedge clk) begin
        if (pop) begin
            fb_mem[wr_addr] <= head_color;
        end
    end

    // scan data one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            scan_color <= '0;
        end else if (scan_req) begin
            scan_color <= fb_mem[rd_addr];
        end
    end

endmodule

// ==== rtl/gpu_draw_top.sv ====
/* 2D drawing engine top, decoder and line walker feed the pixel FIFO
   which the frame writer drains into the framebuffer */
`timescale 1ns/1ns

module gpu_draw_top (
    input  logic                        clk,
    input  logic                        rst,
    input  gpu_pkg::gpu_inst_t          inst,
    input  logic                        inst_valid,
    output logic                        busy,
    input  logic                        scan_req,
    input  logic [gpu_pkg::coord_w-1:0] scan_x,
    input  logic [gpu_pkg::coord_w-1:0] scan_y,
    output logic [gpu_pkg::color_w-1:0] scan_color
);

    // decoder to walker
    logic                        start;
    logic                        finished;
    logic [gpu_pkg::coord_w-1:0] x1;
    logic [gpu_pkg::coord_w-1:0] y1;
    logic [gpu_pkg::coord_w-1:0] x2;
    logic [gpu_pkg::coord_w-1:0] y2;
    logic [gpu_pkg::color_w-1:0] color;

    // the two pixel producers
    logic                        point_push;
    logic [gpu_pkg::coord_w-1:0] point_x;
    logic [gpu_pkg::coord_w-1:0] point_y;
    logic                        line_valid;
    logic [gpu_pkg::coord_w-1:0] line_x;
    logic [gpu_pkg::coord_w-1:0] line_y;

    // FIFO ports
    logic                        push;
    logic [gpu_pkg::coord_w-1:0] px;
    logic [gpu_pkg::coord_w-1:0] py;
    logic [gpu_pkg::color_w-1:0] pcolor;
    logic                        pause;
    logic                        empty;
    logic                        pop;
    logic [gpu_pkg::coord_w-1:0] head_x;
    logic [gpu_pkg::coord_w-1:0] head_y;
    logic [gpu_pkg::color_w-1:0] head_color;

    gpu_inst_decoder dec0 (
        .clk, .rst, .inst, .inst_valid, .finished,
        .fifo_empty (empty),
        .busy, .start, .x1, .y1, .x2, .y2, .color,
        .point_push, .point_x, .point_y
    );

    gpu_func_draw_line line0 (
        .clk, .rst, .pause, .start, .finished,
        .x1, .y1, .x2, .y2,
        .color_in    (color),
        .pos_x       (line_x),
        .pos_y       (line_y),
        .pixel_color (),
        .pixel_valid (line_valid)
    );

    // point and line never overlap, the decoder runs one job at a time
    assign push   = point_push | line_valid;
    assign px     = point_push ? point_x : line_x;
    assign py     = point_push ? point_y : line_y;
    assign pcolor = color;   // decoder picks the view, same colour for both producers

    pixel_fifo fifo0 (
        .clk, .rst, .push, .px, .py, .pcolor, .pop,
        .empty, .head_x, .head_y, .head_color, .pause
    );

    frame_writer wr0 (
        .clk, .rst, .empty, .head_x, .head_y, .head_color, .pop,
        .scan_req, .scan_x, .scan_y, .scan_color
    );

endmodule

// ==== sim/gpu_draw_tb.sv ====
/* testbench for the 2D drawing engine, draws points and lines and
   compares the scanned framebuffer with a shadow Bresenham model */
`timescale 1ns/1ns

module gpu_draw_tb;

    localparam int n_random  = 40;   // random lines
    localparam int scan_hold = 40;   // cycles the scan port stalls the writer
    // full paint + point + 5 directed + 8 octants + 2 stalled lines + random
    localparam int n_inst    = gpu_pkg::fb_words + 16 + n_random;
    localparam int timeout_cycles = n_inst * (32 + 8 + scan_hold) + 8 * gpu_pkg::fb_words;

    logic                        clk;
    logic                        rst;
    gpu_pkg::gpu_inst_t          inst;
    logic                        inst_valid;
    logic                        busy;
    logic                        scan_req;
    logic [gpu_pkg::coord_w-1:0] scan_x;
    logic [gpu_pkg::coord_w-1:0] scan_y;
    logic [gpu_pkg::color_w-1:0] scan_color;

    logic [gpu_pkg::color_w-1:0] shadow [gpu_pkg::fb_words];  // expected frame
    logic [31:0] rng_state;
    int          mism_errs  = 0;
    int          other_errs = 0;
    int          cycles     = 0;

    gpu_draw_top dut0 (
        .clk, .rst, .inst, .inst_valid, .busy,
        .scan_req, .scan_x, .scan_y, .scan_color
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: engine still running after %0d cycles", timeout_cycles);
            $display("%0d mismatches, %0d other errors", mism_errs, other_errs);
            $display("Done: errors found");
            $finish;
        end
    end

    // accepted instruction raises busy next cycle
    assert property (@(posedge clk) disable iff (rst) (inst_valid && !busy) |=> busy)
        else begin
            other_errs++;
            $display("%0t: busy did not rise after an accepted instruction", $time);
        end

    // idle means nothing left in the FIFO
    assert property (@(posedge clk) disable iff (rst) !busy |-> dut0.empty)
        else begin
            other_errs++;
            $display("%0t: busy is low while pixels are still queued", $time);
        end

    function logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // background pattern, every address bit matters
    function automatic logic [gpu_pkg::color_w-1:0] fill_color(input int a);
        return 8'((a * 5) ^ (a >> 3));
    endfunction

    function automatic gpu_pkg::gpu_inst_t make_line(input int x1, input int y1,
                                                     input int x2, input int y2,
                                                     input logic [7:0] c);
        gpu_pkg::gpu_inst_t w;
        w            = '0;
        w.line.op    = gpu_pkg::op_line;
        w.line.x1    = 5'(x1);
        w.line.y1    = 5'(y1);
        w.line.x2    = 5'(x2);
        w.line.y2    = 5'(y2);
        w.line.color = c;
        return w;
    endfunction

    function automatic gpu_pkg::gpu_inst_t make_point(input int x, input int y,
                                                      input logic [7:0] c);
        gpu_pkg::gpu_inst_t w;
        w             = '0;            // pad bits stay zero
        w.point.op    = gpu_pkg::op_point;
        w.point.x     = 5'(x);
        w.point.y     = 5'(y);
        w.point.color = c;
        return w;
    endfunction

    // reference Bresenham walk into the shadow frame
    task automatic model_line(input int x1, input int y1, input int x2, input int y2,
                              input logic [7:0] c);
        int dx, dy, sx, sy, dmaj, dmin, e, x, y, i;
        bit steep;
        dx = x2 - x1;
        dy = y2 - y1;
        sx = (dx < 0) ? -1 : 1;
        sy = (dy < 0) ? -1 : 1;
        dx = (dx < 0) ? -dx : dx;
        dy = (dy < 0) ? -dy : dy;
        steep = (dy > dx);
        dmaj  = steep ? dy : dx;
        dmin  = steep ? dx : dy;
        e = 2 * dmin - dmaj;
        x = x1;
        y = y1;
        for (i = 0; i <= dmaj; i++) begin   // both ends
            shadow[y * 32 + x] = c;
            if (e >= 0) begin
                if (steep) x += sx;
                else y += sy;
                e += 2 * dmin - 2 * dmaj;
            end else begin
                e += 2 * dmin;
            end
            if (steep) y += sy;
            else x += sx;
        end
    endtask

    task automatic issue(input gpu_pkg::gpu_inst_t w);
        @(posedge clk);
        inst       <= w;
        inst_valid <= 1'b1;
        @(posedge clk);
        inst_valid <= 1'b0;   // taken on this edge
    endtask

    // busy is already high at the first negedge after issue
    task automatic wait_idle();
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task automatic expect_pixel(input int a, input logic [7:0] got);
        assert (got === shadow[a]) else begin
            mism_errs++;
            $display("Mismatch at %0t: scan_color x=%0d y=%0d got %h expected %h",
                     $time, a % 32, a / 32, got, shadow[a]);
        end
    endtask

    task automatic draw_point(input int x, input int y, input logic [7:0] c);
        shadow[y * 32 + x] = c;
        issue(make_point(x, y, c));
        wait_idle();
    endtask

    task automatic draw_line(input int x1, input int y1, input int x2, input int y2,
                             input logic [7:0] c);
        model_line(x1, y1, x2, y2, c);
        issue(make_line(x1, y1, x2, y2, c));
        wait_idle();
    endtask

    task automatic read_pixel(input int x, input int y);
        @(posedge clk);
        scan_req <= 1'b1;
        scan_x   <= 5'(x);
        scan_y   <= 5'(y);
        @(posedge clk);
        scan_req <= 1'b0;
        @(negedge clk);            // data one cycle after the request
        expect_pixel(y * 32 + x, scan_color);
    endtask

    // pipelined scan, result for address a-1 shows while a is driven
    task automatic check_frame();
        int a;
        for (a = 0; a <= gpu_pkg::fb_words; a++) begin
            @(posedge clk);
            if (a < gpu_pkg::fb_words) begin
                scan_req <= 1'b1;
                scan_x   <= 5'(a % 32);
                scan_y   <= 5'(a / 32);
            end else begin
                scan_req <= 1'b0;
            end
            @(negedge clk);
            if (a > 0) expect_pixel(a - 1, scan_color);
        end
    endtask

    // long line with the writer blocked by the scan port
    task automatic stall_line(input int x1, input int y1, input int x2, input int y2,
                              input logic [7:0] c, input int lead,
                              input int sx, input int sy);
        int k;
        model_line(x1, y1, x2, y2, c);
        issue(make_line(x1, y1, x2, y2, c));
        repeat (lead) @(posedge clk);
        @(posedge clk);
        scan_req <= 1'b1;
        scan_x   <= 5'(sx);        // pixel off the line, stays put
        scan_y   <= 5'(sy);
        for (k = 0; k < scan_hold; k++) begin
            @(negedge clk);
            assert (busy) else begin
                other_errs++;
                $display("%0t: busy dropped while the scan port stalled the writer", $time);
            end
        end
        expect_pixel(sy * 32 + sx, scan_color);
        @(posedge clk);
        scan_req <= 1'b0;
        wait_idle();               // drain after the stall
    endtask

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        int          i;
        rng_state  = 32'hac8c;
        rst        = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        scan_req   = 1'b0;
        scan_x     = '0;
        scan_y     = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!busy) else begin
            other_errs++;
            $display("%0t: busy is high right after reset", $time);
        end

        // paint the whole frame with points first
        for (i = 0; i < gpu_pkg::fb_words; i++) begin
            draw_point(i % 32, i / 32, fill_color(i));
        end
        draw_point(5, 9, 8'ha5);
        read_pixel(5, 9);
        check_frame();

        // directed lines, both directions
        draw_line(2, 10, 20, 10, 8'he0);    // horizontal
        draw_line(25, 3, 4, 3, 8'h1c);      // horizontal, right to left
        draw_line(7, 1, 7, 30, 8'h03);      // vertical
        draw_line(28, 29, 28, 0, 8'hff);    // vertical, upwards
        draw_line(12, 12, 12, 12, 8'h6d);   // single pixel
        check_frame();

        // one line into each octant from the centre
        draw_line(16, 16, 30, 20, 8'h11);
        draw_line(16, 16, 20, 30, 8'h22);
        draw_line(16, 16, 12, 30, 8'h33);
        draw_line(16, 16, 2, 20, 8'h44);
        draw_line(16, 16, 2, 12, 8'h55);
        draw_line(16, 16, 12, 2, 8'h66);
        draw_line(16, 16, 20, 2, 8'h77);
        draw_line(16, 16, 30, 12, 8'h88);
        for (i = 0; i < n_random; i++) begin
            r1 = lcg_next();
            r2 = lcg_next();
            draw_line(r1[31:27], r1[26:22], r2[31:27], r2[26:22], r1[15:8] ^ r2[15:8]);
        end
        check_frame();

        // scan port holding off the writer
        stall_line(0, 0, 31, 31, 8'hb6, 0, 31, 0);
        stall_line(3, 0, 10, 31, 8'h49, 6, 30, 5);    // steep, stalled mid line
        check_frame();

        $display("%0d mismatches, %0d other errors", mism_errs, other_errs);
        if (mism_errs + other_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/gpu_pkg.sv
rtl/gpu_inst_decoder.sv
rtl/gpu_func_draw_line.sv
rtl/pixel_fifo.sv
rtl/frame_writer.sv
rtl/gpu_draw_top.sv
sim/gpu_draw_tb.sv
